//--- testbench/core_vectors.txt
# I <addr> <instr> | D <addr> <data> | S <name> <addr> <data in lanes> <strb>
# program, upper immediates and alu results
I 80000000 80001537
I 80000004 123450b7
I 80000008 67808093
I 8000000c 00152023
I 80000010 ffb00113
I 80000014 00300193
I 80000018 00208233
I 8000001c 00452023
I 80000020 403082b3
I 80000024 00552023
I 80000028 40315333
I 8000002c 00652023
I 80000030 003153b3
I 80000034 00752023
I 80000038 00409413
I 8000003c 00852023
I 80000040 fff0c493
I 80000044 00952023
I 80000048 003125b3
I 8000004c 00b52023
I 80000050 00313633
I 80000054 00c52023
I 80000058 0f00f693
I 8000005c 00d52023
I 80000060 00001717
I 80000064 00e52023
# branches, taken ones skip a poison add of 0x400
I 80000068 00000793
I 8000006c 00318463
I 80000070 40078793
I 80000074 00310463
I 80000078 00178793
I 8000007c 00311463
I 80000080 40078793
I 80000084 00319463
I 80000088 00278793
I 8000008c 00314463
I 80000090 40078793
I 80000094 0021c463
I 80000098 00478793
I 8000009c 0021d463
I 800000a0 40078793
I 800000a4 00315463
I 800000a8 00878793
I 800000ac 0021e463
I 800000b0 40078793
I 800000b4 00316463
I 800000b8 01078793
I 800000bc 00317463
I 800000c0 40078793
I 800000c4 0021f463
I 800000c8 02078793
I 800000cc 00f52023
# jumps, each skips a poison store
I 800000d0 0080086f
I 800000d4 00252023
I 800000d8 01052023
I 800000dc 010808e7
I 800000e0 00252023
I 800000e4 01152023
# loads, then byte and half stores, then spin
I 800000e8 01150903
I 800000ec 01252023
I 800000f0 01354983
I 800000f4 01352023
I 800000f8 01251a03
I 800000fc 01452023
I 80000100 01055a83
I 80000104 01552023
I 80000108 01052b03
I 8000010c 01652023
I 80000110 001502a3
I 80000114 00151323
I 80000118 0000006f
D 80001010 8192a37f
S lui_addi 80001000 12345678 f
S add 80001000 12345673 f
S sub 80001000 12345675 f
S sra 80001000 ffffffff f
S srl 80001000 1fffffff f
S slli 80001000 23456780 f
S xori 80001000 edcba987 f
S slt 80001000 00000001 f
S sltu 80001000 00000000 f
S andi 80001000 00000070 f
S auipc 80001000 80001060 f
S branches 80001000 0000003f f
S jal_link 80001000 800000d4 f
S jalr_link 80001000 800000e0 f
S lb 80001000 ffffffa3 f
S lbu 80001000 00000081 f
S lh 80001000 ffff8192 f
S lhu 80001000 0000a37f f
S lw 80001000 8192a37f f
S sb 80001004 78787878 2
S sh 80001004 56785678 c

//--- sim.f
common/core_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/instr_decoder.sv
core/core_sequencer.sv
core/risc_core.sv
testbench/core_checker.sv
testbench/tb_core.sv

//--- Makefile
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: run clean

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core > sim.log 2>&1; cat sim.log
	grep -q "all tests passed" sim.log
	! grep -q "tests failed" sim.log

obj_dir/Vtb_core: sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module tb_core -Mdir obj_dir -o Vtb_core

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_core.sv
`timescale 1ns/1ns

module tb_core;

	localparam int fetch_timeout = 20;
	localparam int run_timeout   = 6000;
	localparam int idle_cycles   = 40;

	logic            clock;
	logic            reset;
	core_pkg::word_t iaddr;
	core_pkg::word_t idata;
	logic            ivalid;
	logic            iready;
	core_pkg::word_t daddr;
	core_pkg::word_t dwdata;
	core_pkg::word_t drdata;
	core_pkg::strb_t dstrb;
	logic            dwrite;
	logic            dvalid;
	logic            dready;

	// memory models, keyed by word address
	core_pkg::word_t imem [core_pkg::word_t];
	core_pkg::word_t dmem [core_pkg::word_t];

	// expected store records in program order
	string           exp_name [$];
	core_pkg::word_t exp_addr [$];
	core_pkg::word_t exp_data [$];
	core_pkg::strb_t exp_strb [$];

	int              seed;
	int              iwait;
	int              dwait;
	int              cycles;
	int              store_count;
	int              pass_count;
	int              fail_count;
	logic            fetch_seen;
	logic            early_data;
	core_pkg::word_t first_iaddr;

	risc_core #(
		.RESET_ADDR(32'h8000_0000)
	) dut (
		.clock  (clock),
		.reset  (reset),
		.iaddr  (iaddr),
		.idata  (idata),
		.ivalid (ivalid),
		.iready (iready),
		.daddr  (daddr),
		.dwdata (dwdata),
		.drdata (drdata),
		.dstrb  (dstrb),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.dready (dready)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	task automatic load_vectors();
		int              fd;
		int              n;
		string           kind;
		string           line;
		string           name;
		core_pkg::word_t addr;
		core_pkg::word_t data;
		core_pkg::strb_t strb;
		fd = $fopen("testbench/core_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/core_vectors.txt");
			fail_count++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", kind);
			if (n != 1) begin
				break;
			end
			if (kind == "I") begin
				n = $fscanf(fd, "%h %h", addr, data);
				imem[addr] = data;
			end else if (kind == "D") begin
				n = $fscanf(fd, "%h %h", addr, data);
				dmem[addr] = data;
			end else if (kind == "S") begin
				n = $fscanf(fd, "%s %h %h %h", name, addr, data, strb);
				exp_name.push_back(name);
				exp_addr.push_back(addr);
				exp_data.push_back(data);
				exp_strb.push_back(strb);
			end else begin
				// comment line, drop the rest
				n = $fgets(line, fd);
			end
		end
		$fclose(fd);
	endtask

	// merge a store into the data memory by strobe
	task automatic write_data();
		core_pkg::word_t cur;
		cur = dmem.exists(daddr) ? dmem[daddr] : '0;
		for (int b = 0; b < 4; b++) begin
			if (dstrb[b]) begin
				cur[8*b +: 8] = dwdata[8*b +: 8];
			end
		end
		dmem[daddr] = cur;
	endtask

	task automatic check_store();
		int ok;
		ok = 1;
		if (store_count >= exp_name.size()) begin
			$display("unexpected store of %h to %h after the last expected store",
				dwdata, daddr);
			fail_count++;
			return;
		end
		if (daddr != exp_addr[store_count]) begin
			$display("[ERROR] %s address expected %h actual %h",
				exp_name[store_count], exp_addr[store_count], daddr);
			ok = 0;
		end
		if (dwdata != exp_data[store_count]) begin
			$display("[ERROR] %s data expected %h actual %h",
				exp_name[store_count], exp_data[store_count], dwdata);
			ok = 0;
		end
		if (dstrb != exp_strb[store_count]) begin
			$display("[ERROR] %s strobe expected %h actual %h",
				exp_name[store_count], exp_strb[store_count], dstrb);
			ok = 0;
		end
		if (ok) begin
			pass_count++;
			$display("%s: ok", exp_name[store_count]);
		end else begin
			fail_count++;
			$display("%s: mismatch", exp_name[store_count]);
		end
		store_count++;
	endtask

	// ready delays, driven on the falling edge
	always @(negedge clock) begin
		if (reset) begin
			iready = 1'b0;
			dready = 1'b0;
		end else begin
			if (!ivalid) begin
				iready = 1'b0;
				iwait  = $random(seed) & 3;
			end else if (!iready) begin
				if (iwait == 0) begin
					iready = 1'b1;
					if (imem.exists(iaddr)) begin
						idata = imem[iaddr];
					end else begin
						$display("fetch from unmapped address %h", iaddr);
						fail_count++;
						idata = '0;
					end
				end else begin
					iwait--;
				end
			end
			if (!dvalid) begin
				dready = 1'b0;
				dwait  = $random(seed) & 3;
			end else if (!dready) begin
				if (dwait == 0) begin
					dready = 1'b1;
					drdata = dmem.exists(daddr) ? dmem[daddr] : '0;
				end else begin
					dwait--;
				end
			end
		end
	end

	// handshakes sampled on the rising edge
	always @(posedge clock) begin
		if (!reset) begin
			if (dvalid && !fetch_seen) begin
				early_data = 1'b1;
			end
			if (ivalid && iready && !fetch_seen) begin
				fetch_seen  = 1'b1;
				first_iaddr = iaddr;
			end
			if (dvalid && dready && dwrite) begin
				write_data();
				check_store();
			end
		end
	end

	initial begin
		seed        = 93974;
		iwait       = 0;
		dwait       = 0;
		store_count = 0;
		pass_count  = 0;
		fail_count  = 0;
		fetch_seen  = 1'b0;
		early_data  = 1'b0;
		first_iaddr = '0;
		reset       = 1'b1;
		iready      = 1'b0;
		idata       = '0;
		dready      = 1'b0;
		drdata      = '0;
		load_vectors();
		repeat (8) @(negedge clock);
		// ready process still sees reset high on this edge
		reset <= 1'b0;

		// first fetch after reset
		cycles = 0;
		while (!fetch_seen && cycles < fetch_timeout) begin
			@(negedge clock);
			cycles++;
		end
		if (!fetch_seen) begin
			$display("no fetch accepted within %0d cycles of reset", fetch_timeout);
			fail_count++;
		end else if (first_iaddr != 32'h8000_0000) begin
			$display("[ERROR] reset_fetch expected %h actual %h", 32'h8000_0000, first_iaddr);
			fail_count++;
		end else if (early_data) begin
			$display("data access seen before the first fetch");
			fail_count++;
		end else begin
			pass_count++;
			$display("reset_fetch: ok");
		end

		// run until every expected store is seen
		cycles = 0;
		while (store_count < exp_name.size() && cycles < run_timeout) begin
			@(negedge clock);
			cycles++;
		end
		if (store_count < exp_name.size()) begin
			$display("timeout with %0d of %0d expected stores seen",
				store_count, exp_name.size());
			fail_count++;
		end else begin
			// spin loop, any extra store is flagged
			repeat (idle_cycles) @(negedge clock);
		end

		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- testbench/core_checker.sv
`timescale 1ns/1ns

module core_checker (
	input logic            clock,
	input logic            reset,
	input logic            ivalid,
	input logic            dvalid,
	input logic            dready,
	input logic            dwrite,
	input core_pkg::word_t daddr,
	input core_pkg::word_t dwdata,
	input core_pkg::strb_t dstrb
);

	// one port active at a time
	assert property (@(posedge clock) disable iff (reset) !(ivalid && dvalid))
		else $error("ivalid and dvalid high together");

	// data request stays put until accepted
	assert property (@(posedge clock) disable iff (reset)
		(dvalid && !dready) |=> (dvalid && $stable(daddr) && $stable(dwdata) &&
			$stable(dstrb) && $stable(dwrite)))
		else $error("data request changed while waiting for dready");

	// fetch starts right out of reset
	assert property (@(posedge clock) $fell(reset) |-> ivalid)
		else $error("ivalid low on the first cycle after reset");

endmodule

bind risc_core core_checker u_checker (
	.clock  (clock),
	.reset  (reset),
	.ivalid (ivalid),
	.dvalid (dvalid),
	.dready (dready),
	.dwrite (dwrite),
	.daddr  (daddr),
	.dwdata (dwdata),
	.dstrb  (dstrb)
);

//--- core/risc_core.sv
`timescale 1ns/1ns

module risc_core #(
	parameter core_pkg::word_t RESET_ADDR = 32'h8000_0000
) (
	input  logic            clock,
	input  logic            reset,
	output core_pkg::word_t iaddr,
	input  core_pkg::word_t idata,
	output logic            ivalid,
	input  logic            iready,
	output core_pkg::word_t daddr,
	output core_pkg::word_t dwdata,
	input  core_pkg::word_t drdata,
	output core_pkg::strb_t dstrb,
	output logic            dwrite,
	output logic            dvalid,
	input  logic            dready
);

	// instruction register and pc from the sequencer
	core_pkg::word_t        instr;
	core_pkg::pc_t          pc;

	// decoder results
	core_pkg::instr_class_e instr_class;
	logic [2:0]             funct3;
	core_pkg::reg_addr_t    rs1;
	core_pkg::reg_addr_t    rs2;
	core_pkg::reg_addr_t    rd;
	logic                   branch_cond;
	core_pkg::alu_op_e      alu_op;
	core_pkg::word_t        alu_a;
	core_pkg::word_t        alu_b;
	core_pkg::word_t        alu_result;

	// register file ports
	core_pkg::word_t        rs1_data;
	core_pkg::word_t        rs2_data;
	logic                   rd_wen;
	core_pkg::reg_addr_t    rd_waddr;
	core_pkg::word_t        rd_wdata;

	core_sequencer #(
		.RESET_ADDR(RESET_ADDR)
	) u_sequencer (
		.clock       (clock),
		.reset       (reset),
		.iready      (iready),
		.idata       (idata),
		.dready      (dready),
		.drdata      (drdata),
		.instr_class (instr_class),
		.funct3      (funct3),
		.rd          (rd),
		.branch_cond (branch_cond),
		.alu_result  (alu_result),
		.rs2_data    (rs2_data),
		.instr       (instr),
		.pc          (pc),
		.iaddr       (iaddr),
		.ivalid      (ivalid),
		.daddr       (daddr),
		.dwdata      (dwdata),
		.dstrb       (dstrb),
		.dwrite      (dwrite),
		.dvalid      (dvalid),
		.rd_wen      (rd_wen),
		.rd_waddr    (rd_waddr),
		.rd_wdata    (rd_wdata)
	);

	instr_decoder u_decoder (
		.instr       (instr),
		.pc          (pc),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.instr_class (instr_class),
		.funct3      (funct3),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd          (rd),
		.branch_cond (branch_cond),
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b)
	);

	reg_file u_reg_file (
		.clock    (clock),
		.reset    (reset),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd_wen   (rd_wen),
		.rd_waddr (rd_waddr),
		.rd_wdata (rd_wdata),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	alu u_alu (
		.alu_op     (alu_op),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.alu_result (alu_result)
	);

endmodule

//--- core/core_sequencer.sv
`timescale 1ns/1ns

module core_sequencer #(
	parameter core_pkg::word_t RESET_ADDR = 32'h8000_0000
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   iready,
	input  core_pkg::word_t        idata,
	input  logic                   dready,
	input  core_pkg::word_t        drdata,
	input  core_pkg::instr_class_e instr_class,
	input  logic [2:0]             funct3,
	input  core_pkg::reg_addr_t    rd,
	input  logic                   branch_cond,
	input  core_pkg::word_t        alu_result,
	input  core_pkg::word_t        rs2_data,
	output core_pkg::word_t        instr,
	output core_pkg::pc_t          pc,
	output core_pkg::word_t        iaddr,
	output logic                   ivalid,
	output core_pkg::word_t        daddr,
	output core_pkg::word_t        dwdata,
	output core_pkg::strb_t        dstrb,
	output logic                   dwrite,
	output logic                   dvalid,
	output logic                   rd_wen,
	output core_pkg::reg_addr_t    rd_waddr,
	output core_pkg::word_t        rd_wdata
);

	core_pkg::core_state_e state;
	core_pkg::pc_t         pc_inc;
	core_pkg::pc_t         pc_next;
	logic                  take_target;
	logic [1:0]            lane;
	logic [7:0]            ld_byte;
	logic [15:0]           ld_half;
	logic                  ld_signed;
	core_pkg::word_t       load_data;

	assign pc_inc = pc + 30'd1;

	// jumps and taken branches follow the alu target
	assign take_target = (instr_class == core_pkg::cls_jal) ||
		(instr_class == core_pkg::cls_jalr) ||
		(instr_class == core_pkg::cls_branch && branch_cond);
	assign pc_next = take_target ? alu_result[31:2] : pc_inc;

	// fetch port
	assign iaddr  = {pc, 2'b00};
	assign ivalid = (state == core_pkg::fetch);

	// data port, address always from the alu
	assign dvalid = (state == core_pkg::mem_read) || (state == core_pkg::mem_write);
	assign dwrite = (state == core_pkg::mem_write);
	assign daddr  = {alu_result[31:2], 2'b00};
	assign lane   = alu_result[1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= core_pkg::fetch;
			pc    <= RESET_ADDR[31:2];
			instr <= '0;
		end else begin
			case (state)
				core_pkg::fetch: begin
					// hold until the fetch handshake
					if (iready) begin
						instr <= idata;
						state <= core_pkg::decode;
					end
				end
				core_pkg::decode: begin
					// register reads launch here
					state <= core_pkg::execute;
				end
				core_pkg::execute: begin
					if (instr_class == core_pkg::cls_load) begin
						state <= core_pkg::mem_read;
					end else if (instr_class == core_pkg::cls_store) begin
						state <= core_pkg::mem_write;
					end else begin
						pc    <= pc_next;
						state <= core_pkg::fetch;
					end
				end
				core_pkg::mem_read, core_pkg::mem_write: begin
					// access ends on the data handshake
					if (dready) begin
						pc    <= pc_inc;
						state <= core_pkg::fetch;
					end
				end
				default: begin
					state <= core_pkg::fetch;
				end
			endcase
		end
	end

	// store lanes and strobes, byte and half replicated
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				dstrb  = 4'b0001 << lane;
				dwdata = {4{rs2_data[7:0]}};
			end
			2'b01: begin
				dstrb  = 4'b0011 << {lane[1], 1'b0};
				dwdata = {2{rs2_data[15:0]}};
			end
			default: begin
				dstrb  = 4'b1111;
				dwdata = rs2_data;
			end
		endcase
	end

	// load lane extraction
	assign ld_signed = !funct3[2];
	assign ld_half   = lane[1] ? drdata[31:16] : drdata[15:0];

	always_comb begin
		case (lane)
			2'b00:   ld_byte = drdata[7:0];
			2'b01:   ld_byte = drdata[15:8];
			2'b10:   ld_byte = drdata[23:16];
			default: ld_byte = drdata[31:24];
		endcase
	end

	always_comb begin
		case (funct3[1:0])
			2'b00:   load_data = {{24{ld_signed & ld_byte[7]}}, ld_byte};
			2'b01:   load_data = {{16{ld_signed & ld_half[15]}}, ld_half};
			default: load_data = drdata;
		endcase
	end

	// writeback, at the end of execute or on the load handshake
	assign rd_waddr = rd;

	always_comb begin
		case (state)
			core_pkg::execute: begin
				rd_wen = (instr_class == core_pkg::cls_lui) ||
					(instr_class == core_pkg::cls_auipc) ||
					(instr_class == core_pkg::cls_jal) ||
					(instr_class == core_pkg::cls_jalr) ||
					(instr_class == core_pkg::cls_op_imm) ||
					(instr_class == core_pkg::cls_op);
			end
			core_pkg::mem_read: rd_wen = dready;
			default:            rd_wen = 1'b0;
		endcase
	end

	always_comb begin
		if (instr_class == core_pkg::cls_jal || instr_class == core_pkg::cls_jalr) begin
			// link address
			rd_wdata = {pc_inc, 2'b00};
		end else if (instr_class == core_pkg::cls_load) begin
			rd_wdata = load_data;
		end else begin
			rd_wdata = alu_result;
		end
	end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
	input  core_pkg::word_t        instr,
	input  core_pkg::pc_t          pc,
	input  core_pkg::word_t        rs1_data,
	input  core_pkg::word_t        rs2_data,
	output core_pkg::instr_class_e instr_class,
	output logic [2:0]             funct3,
	output core_pkg::reg_addr_t    rs1,
	output core_pkg::reg_addr_t    rs2,
	output core_pkg::reg_addr_t    rd,
	output logic                   branch_cond,
	output core_pkg::alu_op_e      alu_op,
	output core_pkg::word_t        alu_a,
	output core_pkg::word_t        alu_b
);

	core_pkg::word_t imm_i;
	core_pkg::word_t imm_s;
	core_pkg::word_t imm_b;
	core_pkg::word_t imm_u;
	core_pkg::word_t imm_j;
	core_pkg::word_t pc_word;
	logic            cmp_eq;
	logic            cmp_lt;
	logic            cmp_ltu;
	logic            cmp_sel;

	// fields sit in the same place for every format
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	assign pc_word = {pc, 2'b00};

	// sign-extended immediates
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (instr[6:0])
			core_pkg::opc_lui:    instr_class = core_pkg::cls_lui;
			core_pkg::opc_auipc:  instr_class = core_pkg::cls_auipc;
			core_pkg::opc_jal:    instr_class = core_pkg::cls_jal;
			core_pkg::opc_jalr:   instr_class = core_pkg::cls_jalr;
			core_pkg::opc_branch: instr_class = core_pkg::cls_branch;
			core_pkg::opc_load:   instr_class = core_pkg::cls_load;
			core_pkg::opc_store:  instr_class = core_pkg::cls_store;
			core_pkg::opc_op_imm: instr_class = core_pkg::cls_op_imm;
			core_pkg::opc_op:     instr_class = core_pkg::cls_op;
			// fence and the rest fall through
			default:              instr_class = core_pkg::cls_other;
		endcase
	end

	// branch compare kept apart, the alu forms the target
	assign cmp_eq  = (rs1_data == rs2_data);
	assign cmp_lt  = ($signed(rs1_data) < $signed(rs2_data));
	assign cmp_ltu = (rs1_data < rs2_data);

	always_comb begin
		case (funct3[2:1])
			2'b00:   cmp_sel = cmp_eq;
			2'b10:   cmp_sel = cmp_lt;
			2'b11:   cmp_sel = cmp_ltu;
			default: cmp_sel = 1'b0;
		endcase
	end

	// odd funct3 inverts: bne, bge, bgeu
	assign branch_cond = funct3[0] ? !cmp_sel : cmp_sel;

	// operand select
	always_comb begin
		alu_a = rs1_data;
		alu_b = imm_i;
		case (instr_class)
			core_pkg::cls_lui: begin
				alu_a = imm_u;
				alu_b = '0;
			end
			core_pkg::cls_auipc: begin
				alu_a = pc_word;
				alu_b = imm_u;
			end
			core_pkg::cls_jal: begin
				alu_a = pc_word;
				alu_b = imm_j;
			end
			core_pkg::cls_branch: begin
				alu_a = pc_word;
				alu_b = imm_b;
			end
			core_pkg::cls_store: alu_b = imm_s;
			core_pkg::cls_op:    alu_b = rs2_data;
			// jalr, load, op_imm use rs1 plus imm_i
			default: ;
		endcase
	end

	// operation, only arithmetic classes use funct3
	always_comb begin
		alu_op = core_pkg::op_add;
		if (instr_class == core_pkg::cls_op || instr_class == core_pkg::cls_op_imm) begin
			case (funct3)
				3'b000: begin
					// sub only in the register form
					if (instr_class == core_pkg::cls_op && instr[30]) begin
						alu_op = core_pkg::op_sub;
					end else begin
						alu_op = core_pkg::op_add;
					end
				end
				3'b001:  alu_op = core_pkg::op_sll;
				3'b010:  alu_op = core_pkg::op_slt;
				3'b011:  alu_op = core_pkg::op_sltu;
				3'b100:  alu_op = core_pkg::op_xor;
				3'b101:  alu_op = instr[30] ? core_pkg::op_sra : core_pkg::op_srl;
				3'b110:  alu_op = core_pkg::op_or;
				default: alu_op = core_pkg::op_and;
			endcase
		end
	end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic                clock,
	input  logic                reset,
	input  core_pkg::reg_addr_t rs1,
	input  core_pkg::reg_addr_t rs2,
	input  logic                rd_wen,
	input  core_pkg::reg_addr_t rd_waddr,
	input  core_pkg::word_t     rd_wdata,
	output core_pkg::word_t     rs1_data,
	output core_pkg::word_t     rs2_data
);

	core_pkg::word_t regs [32];

	// x0 never written
	always_ff @(posedge clock) begin
		if (rd_wen && rd_waddr != 5'd0) begin
			regs[rd_waddr] <= rd_wdata;
		end
	end

	// registered reads, x0 reads as zero
	always_ff @(posedge clock) begin
		if (reset) begin
			rs1_data <= '0;
			rs2_data <= '0;
		end else begin
			rs1_data <= (rs1 == 5'd0) ? '0 : regs[rs1];
			rs2_data <= (rs2 == 5'd0) ? '0 : regs[rs2];
		end
	end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
	input  core_pkg::alu_op_e alu_op,
	input  core_pkg::word_t   alu_a,
	input  core_pkg::word_t   alu_b,
	output core_pkg::word_t   alu_result
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// shift amount from the low bits of b, immediate or rs2
	assign shamt = alu_b[4:0];

	assign lt_signed   = ($signed(alu_a) < $signed(alu_b));
	assign lt_unsigned = (alu_a < alu_b);

	always_comb begin
		case (alu_op)
			core_pkg::op_add:  alu_result = alu_a + alu_b;
			core_pkg::op_sub:  alu_result = alu_a - alu_b;
			core_pkg::op_sll:  alu_result = alu_a << shamt;
			core_pkg::op_srl:  alu_result = alu_a >> shamt;
			core_pkg::op_sra:  alu_result = $signed(alu_a) >>> shamt;
			core_pkg::op_xor:  alu_result = alu_a ^ alu_b;
			core_pkg::op_or:   alu_result = alu_a | alu_b;
			core_pkg::op_and:  alu_result = alu_a & alu_b;
			// compares give 0 or 1
			core_pkg::op_slt:  alu_result = {31'd0, lt_signed};
			core_pkg::op_sltu: alu_result = {31'd0, lt_unsigned};
			default:           alu_result = alu_a + alu_b;
		endcase
	end

endmodule

//--- common/core_pkg.sv
package core_pkg;

	// data, address and instruction word
	typedef logic [31:0] word_t;

	// register index
	typedef logic [4:0] reg_addr_t;

	// word-aligned pc, address bits 31 to 2
	typedef logic [29:0] pc_t;

	// byte-lane write strobes
	typedef logic [3:0] strb_t;

	// major opcodes of the kept rv32i subset
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	// instruction class seen by the sequencer
	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store,
		cls_op_imm,
		cls_op,
		cls_other
	} instr_class_e;

	// alu operation
	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_sll,
		op_srl,
		op_sra,
		op_xor,
		op_or,
		op_and,
		op_slt,
		op_sltu
	} alu_op_e;

	// sequencer state
	typedef enum logic [2:0] {
		fetch,
		decode,
		execute,
		mem_read,
		mem_write
	} core_state_e;

endpackage
